//--- Makefile
TOP = tb_fm_regs

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1 || { cat sim.log; exit 1; }
	cat sim.log
	! grep -q "STATUS: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

//--- build.f
fm_reg_map_pkg.sv
fm_host_pkg.sv
fm_prescaler.sv
fm_mmr.sv
fm_slot_regs.sv
fm_timers.sv
fm_regs_top.sv
tb_fm_regs.sv

//--- fm_host_pkg.sv
package fm_host_pkg;

	// wishbone port map, adr[1] selects the bank
	parameter logic [1:0] PORT_ADDR0 = 2'd0;
	parameter logic [1:0] PORT_DATA0 = 2'd1;
	parameter logic [1:0] PORT_ADDR1 = 2'd2;
	parameter logic [1:0] PORT_DATA1 = 2'd3;

	// status byte, returned on every read
	parameter int ST_BUSY   = 7;
	parameter int ST_FLAG_B = 1;
	parameter int ST_FLAG_A = 0;

endpackage

//--- fm_mmr.sv
`timescale 1ns/100ps

module fm_mmr (
	input  logic       clk,
	input  logic       rst,
	input  logic       cyc,
	input  logic       stb,
	input  logic       we,
	input  logic [1:0] adr,
	input  logic [7:0] dat_w,
	output logic [7:0] dat_r,
	output logic       ack,
	input  logic       upd_done,
	output logic       upd_req,
	output logic [7:0] upd_grp,
	output logic [2:0] upd_ch,
	output logic [1:0] upd_op,
	output logic [7:0] upd_data,
	output logic [1:0] div_sel,
	output logic       div_load,
	output logic [9:0] value_a,
	output logic [7:0] value_b,
	output logic       load_a,
	output logic       load_b,
	output logic       en_flag_a,
	output logic       en_flag_b,
	output logic       clr_a,
	output logic       clr_b,
	input  logic       flag_a,
	input  logic       flag_b,
	output logic       lfo_en,
	output logic [2:0] lfo_freq,
	output logic [8:0] pcm,
	output logic       pcm_en,
	output logic       eg_stop,
	output logic       pg_stop
);

	localparam logic [1:0] SEL_RESET =
		(fm_reg_map_pkg::DIV_RESET == 2) ? 2'd2 :
		(fm_reg_map_pkg::DIV_RESET == 3) ? 2'd1 : 2'd0;

	logic [7:0] sel_reg;
	logic       bank;
	// ack already given, wait for stb to drop
	logic       done;
	logic       is_addr;
	logic       is_data;
	logic       accept;
	logic       wr_addr;
	logic       wr_data;
	logic [7:0] ch_grp;
	logic       ch_hit;
	logic       op_hit;
	logic       kon_req;
	logic       slot_req;

	// bank 1 channels follow bank 0 ones, 0..2 then 3..5
	function automatic logic [2:0] lin_ch(input logic hi, input logic [1:0] lo);
		return hi ? 3'd3 + {1'b0, lo} : {1'b0, lo};
	endfunction

	assign is_addr = adr == fm_host_pkg::PORT_ADDR0 || adr == fm_host_pkg::PORT_ADDR1;
	assign is_data = adr == fm_host_pkg::PORT_DATA0 || adr == fm_host_pkg::PORT_DATA1;

	// data writes are held off while a slot update is in flight
	assign accept  = cyc && stb && !ack && !done && !(we && is_data && upd_req);
	// the bus is still held in the ack cycle, the write lands at its end
	assign wr_addr = ack && we && is_addr;
	assign wr_data = ack && we && is_data;

	assign ch_grp = {sel_reg[7:2], 2'b00};
	assign ch_hit = ch_grp == fm_reg_map_pkg::GRP_FNUM_LO ||
		ch_grp == fm_reg_map_pkg::GRP_BLOCK ||
		ch_grp == fm_reg_map_pkg::GRP_FB_ALG ||
		ch_grp == fm_reg_map_pkg::GRP_PMS;
	assign op_hit = sel_reg[7:4] >= fm_reg_map_pkg::GRP_DT1_MUL &&
		sel_reg[7:4] <= fm_reg_map_pkg::GRP_SSG;

	// channel codes 3 and 7 do not exist
	assign kon_req  = wr_data && !bank && sel_reg == fm_reg_map_pkg::REG_KON &&
		dat_w[1:0] != 2'b11;
	assign slot_req = wr_data && sel_reg[1:0] != 2'b11 && (ch_hit || op_hit);

	always_comb begin
		dat_r = '0;
		dat_r[fm_host_pkg::ST_BUSY]   = upd_req;
		dat_r[fm_host_pkg::ST_FLAG_B] = flag_b;
		dat_r[fm_host_pkg::ST_FLAG_A] = flag_a;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ack       <= 1'b0;
			done      <= 1'b0;
			sel_reg   <= '0;
			bank      <= 1'b0;
			upd_req   <= 1'b0;
			div_sel   <= SEL_RESET;
			div_load  <= 1'b0;
			value_a   <= '0;
			value_b   <= '0;
			load_a    <= 1'b0;
			load_b    <= 1'b0;
			en_flag_a <= 1'b0;
			en_flag_b <= 1'b0;
			clr_a     <= 1'b0;
			clr_b     <= 1'b0;
			lfo_en    <= 1'b0;
			lfo_freq  <= '0;
			pcm       <= '0;
			pcm_en    <= 1'b0;
			eg_stop   <= 1'b0;
			pg_stop   <= 1'b0;
		end else begin
			ack      <= accept;
			div_load <= 1'b0;
			clr_a    <= 1'b0;
			clr_b    <= 1'b0;
			if (ack) begin
				done <= 1'b1;
			end else if (!stb) begin
				done <= 1'b0;
			end
			// busy is the pending request itself
			if (kon_req || slot_req) begin
				upd_req <= 1'b1;
			end else if (upd_done) begin
				upd_req <= 1'b0;
			end
			if (wr_addr) begin
				sel_reg <= dat_w;
				bank    <= adr[1];
			end
			if (wr_data && !bank) begin
				case (sel_reg)
					fm_reg_map_pkg::REG_TESTYM: begin
						eg_stop <= dat_w[5];
						pg_stop <= dat_w[3];
					end
					fm_reg_map_pkg::REG_LFO: begin
						lfo_en   <= dat_w[3];
						lfo_freq <= dat_w[2:0];
					end
					fm_reg_map_pkg::REG_CLKA1: value_a[9:2] <= dat_w;
					fm_reg_map_pkg::REG_CLKA2: value_a[1:0] <= dat_w[1:0];
					fm_reg_map_pkg::REG_CLKB:  value_b <= dat_w;
					fm_reg_map_pkg::REG_TIMER: begin
						load_a    <= dat_w[0];
						load_b    <= dat_w[1];
						en_flag_a <= dat_w[2];
						en_flag_b <= dat_w[3];
						clr_a     <= dat_w[4];
						clr_b     <= dat_w[5];
					end
					// pcm msbs in 2Ah, lsb rides on the dac test register
					fm_reg_map_pkg::REG_PCM:     pcm[8:1] <= dat_w;
					fm_reg_map_pkg::REG_DACTEST: pcm[0] <= dat_w[3];
					fm_reg_map_pkg::REG_PCM_EN:  pcm_en <= dat_w[7];
					fm_reg_map_pkg::REG_CLK_N6: begin
						div_sel  <= 2'd0;
						div_load <= 1'b1;
					end
					fm_reg_map_pkg::REG_CLK_N3: begin
						div_sel  <= 2'd1;
						div_load <= 1'b1;
					end
					fm_reg_map_pkg::REG_CLK_N2: begin
						div_sel  <= 2'd2;
						div_load <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// request payload, only looked at while upd_req is high
	always_ff @(posedge clk) begin
		if (kon_req) begin
			upd_grp  <= fm_reg_map_pkg::REG_KON;
			upd_ch   <= lin_ch(dat_w[2], dat_w[1:0]);
			upd_op   <= 2'd0;
			upd_data <= dat_w;
		end else if (slot_req) begin
			upd_grp  <= ch_hit ? ch_grp : {sel_reg[7:4], 4'h0};
			upd_ch   <= lin_ch(bank, sel_reg[1:0]);
			upd_op   <= sel_reg[3:2];
			upd_data <= dat_w;
		end
	end

	a_ack_after_stb: assert property (@(posedge clk) disable iff (rst)
		ack |-> $past(cyc && stb) && !$past(ack));

	// a pending request stays put until the ring takes it
	a_upd_held: assert property (@(posedge clk) disable iff (rst)
		upd_req && !upd_done |=> upd_req && $stable(upd_grp) && $stable(upd_ch) &&
			$stable(upd_op) && $stable(upd_data));

endmodule

//--- fm_prescaler.sv
`timescale 1ns/100ps

module fm_prescaler (
	input  logic       clk,
	input  logic       rst,
	input  logic [1:0] div_sel,
	input  logic       div_load,
	output logic       slot_en
);

	logic [2:0] cnt;
	logic [2:0] div_act;
	logic [2:0] div_next;

	// one pulse on the last clock of each period
	assign slot_en = cnt == div_act - 3'd1;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt      <= '0;
			div_act  <= 3'(fm_reg_map_pkg::DIV_RESET);
			div_next <= 3'(fm_reg_map_pkg::DIV_RESET);
		end else begin
			// codes 0, 1, 2 stand for 6, 3 and 2 clocks
			if (div_load) begin
				case (div_sel)
					2'd1:    div_next <= 3'd3;
					2'd2:    div_next <= 3'd2;
					default: div_next <= 3'd6;
				endcase
			end
			// new divisor only at a wrap, so no short period
			if (slot_en) begin
				cnt     <= '0;
				div_act <= div_next;
			end else begin
				cnt <= cnt + 3'd1;
			end
		end
	end

	a_slot_en_single: assert property (@(posedge clk) disable iff (rst)
		slot_en && div_act >= 3'd2 |=> !slot_en);

endmodule

//--- fm_reg_map_pkg.sv
package fm_reg_map_pkg;

	// global registers, bank 0 only
	parameter logic [7:0] REG_TESTYM  = 8'h21;
	parameter logic [7:0] REG_LFO     = 8'h22;
	parameter logic [7:0] REG_CLKA1   = 8'h24;
	parameter logic [7:0] REG_CLKA2   = 8'h25;
	parameter logic [7:0] REG_CLKB    = 8'h26;
	parameter logic [7:0] REG_TIMER   = 8'h27;
	parameter logic [7:0] REG_KON     = 8'h28;
	parameter logic [7:0] REG_PCM     = 8'h2A;
	parameter logic [7:0] REG_PCM_EN  = 8'h2B;
	parameter logic [7:0] REG_DACTEST = 8'h2C;
	parameter logic [7:0] REG_CLK_N6  = 8'h2D;
	parameter logic [7:0] REG_CLK_N3  = 8'h2E;
	parameter logic [7:0] REG_CLK_N2  = 8'h2F;

	// operator groups, upper nibble of the address
	// bits 3..2 pick the operator, bits 1..0 the channel
	parameter logic [3:0] GRP_DT1_MUL = 4'h3;
	parameter logic [3:0] GRP_TL      = 4'h4;
	parameter logic [3:0] GRP_KS_AR   = 4'h5;
	parameter logic [3:0] GRP_AM_D1R  = 4'h6;
	parameter logic [3:0] GRP_D2R     = 4'h7;
	parameter logic [3:0] GRP_D1L_RR  = 4'h8;
	parameter logic [3:0] GRP_SSG     = 4'h9;

	// channel groups, channel in bits 1..0
	parameter logic [7:0] GRP_FNUM_LO = 8'hA0;
	parameter logic [7:0] GRP_BLOCK   = 8'hA4;
	parameter logic [7:0] GRP_FB_ALG  = 8'hB0;
	parameter logic [7:0] GRP_PMS     = 8'hB4;

	// slot ring
	parameter int OPS_PER_CH = 4;

	// clocks per slot out of reset
	parameter int DIV_RESET = 6;

endpackage

//--- fm_regs_top.sv
`timescale 1ns/100ps

module fm_regs_top #(
	parameter int NUM_CH = 6,
	localparam int SLOT_W = $clog2(NUM_CH * fm_reg_map_pkg::OPS_PER_CH)
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              cyc,
	input  logic              stb,
	input  logic              we,
	input  logic [1:0]        adr,
	input  logic [7:0]        dat_w,
	output logic [7:0]        dat_r,
	output logic              ack,
	output logic              irq,
	output logic [SLOT_W-1:0] slot_idx,
	output logic              keyon,
	output logic [2:0]        dt1,
	output logic [3:0]        mul,
	output logic [6:0]        tl,
	output logic [1:0]        ks,
	output logic [4:0]        ar,
	output logic [4:0]        d1r,
	output logic [4:0]        d2r,
	output logic [3:0]        d1l,
	output logic [3:0]        rr,
	output logic [3:0]        ssg_eg,
	output logic [10:0]       fnum,
	output logic [2:0]        block,
	output logic [2:0]        fb,
	output logic [2:0]        alg,
	output logic              lfo_en,
	output logic [2:0]        lfo_freq,
	output logic [8:0]        pcm,
	output logic              pcm_en,
	output logic              eg_stop,
	output logic              pg_stop
);

	logic       slot_en;
	logic [1:0] div_sel;
	logic       div_load;
	logic       upd_req;
	logic [7:0] upd_grp;
	logic [2:0] upd_ch;
	logic [1:0] upd_op;
	logic [7:0] upd_data;
	logic       upd_done;
	logic [9:0] value_a;
	logic [7:0] value_b;
	logic       load_a;
	logic       load_b;
	logic       en_flag_a;
	logic       en_flag_b;
	logic       clr_a;
	logic       clr_b;
	logic       flag_a;
	logic       flag_b;
	logic       ring_wrap;

	fm_prescaler i_prescaler (
		.clk      (clk),
		.rst      (rst),
		.div_sel  (div_sel),
		.div_load (div_load),
		.slot_en  (slot_en)
	);

	fm_mmr i_mmr (
		.clk       (clk),
		.rst       (rst),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.dat_w     (dat_w),
		.dat_r     (dat_r),
		.ack       (ack),
		.upd_done  (upd_done),
		.upd_req   (upd_req),
		.upd_grp   (upd_grp),
		.upd_ch    (upd_ch),
		.upd_op    (upd_op),
		.upd_data  (upd_data),
		.div_sel   (div_sel),
		.div_load  (div_load),
		.value_a   (value_a),
		.value_b   (value_b),
		.load_a    (load_a),
		.load_b    (load_b),
		.en_flag_a (en_flag_a),
		.en_flag_b (en_flag_b),
		.clr_a     (clr_a),
		.clr_b     (clr_b),
		.flag_a    (flag_a),
		.flag_b    (flag_b),
		.lfo_en    (lfo_en),
		.lfo_freq  (lfo_freq),
		.pcm       (pcm),
		.pcm_en    (pcm_en),
		.eg_stop   (eg_stop),
		.pg_stop   (pg_stop)
	);

	fm_slot_regs #(
		.NUM_CH (NUM_CH)
	) i_slot_regs (
		.clk       (clk),
		.rst       (rst),
		.slot_en   (slot_en),
		.upd_req   (upd_req),
		.upd_grp   (upd_grp),
		.upd_ch    (upd_ch),
		.upd_op    (upd_op),
		.upd_data  (upd_data),
		.upd_done  (upd_done),
		.slot_idx  (slot_idx),
		.keyon     (keyon),
		.dt1       (dt1),
		.mul       (mul),
		.tl        (tl),
		.ks        (ks),
		.ar        (ar),
		.d1r       (d1r),
		.d2r       (d2r),
		.d1l       (d1l),
		.rr        (rr),
		.ssg_eg    (ssg_eg),
		.fnum      (fnum),
		.block     (block),
		.fb        (fb),
		.alg       (alg),
		.ring_wrap (ring_wrap)
	);

	fm_timers #(
		.NUM_CH (NUM_CH)
	) i_timers (
		.clk       (clk),
		.rst       (rst),
		.ring_wrap (ring_wrap),
		.value_a   (value_a),
		.value_b   (value_b),
		.load_a    (load_a),
		.load_b    (load_b),
		.en_flag_a (en_flag_a),
		.en_flag_b (en_flag_b),
		.clr_a     (clr_a),
		.clr_b     (clr_b),
		.flag_a    (flag_a),
		.flag_b    (flag_b),
		.irq       (irq)
	);

endmodule

//--- fm_slot_regs.sv
`timescale 1ns/100ps

module fm_slot_regs #(
	parameter int NUM_CH = 6,
	localparam int NUM_SLOT = NUM_CH * fm_reg_map_pkg::OPS_PER_CH,
	localparam int SLOT_W = $clog2(NUM_SLOT)
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              slot_en,
	input  logic              upd_req,
	input  logic [7:0]        upd_grp,
	input  logic [2:0]        upd_ch,
	input  logic [1:0]        upd_op,
	input  logic [7:0]        upd_data,
	output logic              upd_done,
	output logic [SLOT_W-1:0] slot_idx,
	output logic              keyon,
	output logic [2:0]        dt1,
	output logic [3:0]        mul,
	output logic [6:0]        tl,
	output logic [1:0]        ks,
	output logic [4:0]        ar,
	output logic [4:0]        d1r,
	output logic [4:0]        d2r,
	output logic [3:0]        d1l,
	output logic [3:0]        rr,
	output logic [3:0]        ssg_eg,
	output logic [10:0]       fnum,
	output logic [2:0]        block,
	output logic [2:0]        fb,
	output logic [2:0]        alg,
	output logic              ring_wrap
);

	localparam int OPS = fm_reg_map_pkg::OPS_PER_CH;
	localparam logic [SLOT_W-1:0] LAST = SLOT_W'(NUM_SLOT - 1);

	logic [SLOT_W-1:0] cur;
	logic [SLOT_W-1:0] nxt;
	logic [2:0]        cur_ch;
	logic [2:0]        nxt_ch;
	logic [1:0]        nxt_op;
	logic              is_ch_grp;
	logic              ch_ok;
	logic              hit;
	logic              wr_slot;

	// per slot
	logic [2:0]  dt1_m [NUM_SLOT];
	logic [3:0]  mul_m [NUM_SLOT];
	logic [6:0]  tl_m  [NUM_SLOT];
	logic [1:0]  ks_m  [NUM_SLOT];
	logic [4:0]  ar_m  [NUM_SLOT];
	logic [4:0]  d1r_m [NUM_SLOT];
	logic [4:0]  d2r_m [NUM_SLOT];
	logic [3:0]  d1l_m [NUM_SLOT];
	logic [3:0]  rr_m  [NUM_SLOT];
	logic [3:0]  ssg_m [NUM_SLOT];
	logic        kon_m [NUM_SLOT];
	// per channel
	logic [10:0] fnum_m  [NUM_CH];
	logic [2:0]  block_m [NUM_CH];
	logic [2:0]  fb_m    [NUM_CH];
	logic [2:0]  alg_m   [NUM_CH];
	// block and fnum msbs from A4h, waiting for A0h
	logic [5:0]  blk_latch;

	assign nxt    = (cur == LAST) ? '0 : cur + 1'b1;
	assign cur_ch = 3'(cur / OPS);
	assign nxt_ch = 3'(nxt / OPS);
	assign nxt_op = 2'(nxt % OPS);

	// the update lands on the slot the ring is about to enter
	assign is_ch_grp = upd_grp[7:4] >= fm_reg_map_pkg::GRP_FNUM_LO[7:4] ||
		upd_grp == fm_reg_map_pkg::REG_KON;
	// bank 1 channels missing when NUM_CH is 3, complete without a write
	assign ch_ok    = upd_ch < NUM_CH;
	assign hit      = !ch_ok || (nxt_ch == upd_ch && (is_ch_grp || nxt_op == upd_op));
	assign upd_done = upd_req && slot_en && hit;
	assign wr_slot  = upd_done && ch_ok;

	always_ff @(posedge clk) begin
		if (wr_slot) begin
			case (upd_grp)
				{fm_reg_map_pkg::GRP_DT1_MUL, 4'h0}: begin
					dt1_m[nxt] <= upd_data[6:4];
					mul_m[nxt] <= upd_data[3:0];
				end
				{fm_reg_map_pkg::GRP_TL, 4'h0}: tl_m[nxt] <= upd_data[6:0];
				{fm_reg_map_pkg::GRP_KS_AR, 4'h0}: begin
					ks_m[nxt] <= upd_data[7:6];
					ar_m[nxt] <= upd_data[4:0];
				end
				// am enable in bit 7 is not carried
				{fm_reg_map_pkg::GRP_AM_D1R, 4'h0}: d1r_m[nxt] <= upd_data[4:0];
				{fm_reg_map_pkg::GRP_D2R, 4'h0}:    d2r_m[nxt] <= upd_data[4:0];
				{fm_reg_map_pkg::GRP_D1L_RR, 4'h0}: begin
					d1l_m[nxt] <= upd_data[7:4];
					rr_m[nxt]  <= upd_data[3:0];
				end
				{fm_reg_map_pkg::GRP_SSG, 4'h0}: ssg_m[nxt] <= upd_data[3:0];
				fm_reg_map_pkg::GRP_BLOCK:       blk_latch <= upd_data[5:0];
				fm_reg_map_pkg::GRP_FNUM_LO: begin
					fnum_m[nxt_ch]  <= {blk_latch[2:0], upd_data};
					block_m[nxt_ch] <= blk_latch[5:3];
				end
				fm_reg_map_pkg::GRP_FB_ALG: begin
					fb_m[nxt_ch]  <= upd_data[5:3];
					alg_m[nxt_ch] <= upd_data[2:0];
				end
				// pms and ams have no consumer yet, the write just retires
				fm_reg_map_pkg::GRP_PMS: ;
				default: ;
			endcase
		end
	end

	// key-on mask bit 4+n drives operator n of the channel
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_SLOT; i++) begin
				kon_m[i] <= 1'b0;
			end
		end else if (wr_slot && upd_grp == fm_reg_map_pkg::REG_KON) begin
			for (int i = 0; i < OPS; i++) begin
				kon_m[nxt_ch * OPS + i] <= upd_data[4 + i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cur       <= '0;
			slot_idx  <= '0;
			ring_wrap <= 1'b0;
			keyon     <= 1'b0;
		end else begin
			if (slot_en) begin
				cur <= nxt;
			end
			ring_wrap <= slot_en && cur == LAST;
			slot_idx  <= cur;
			keyon     <= kon_m[cur];
		end
	end

	// parameters of the current slot, one clock behind the index
	always_ff @(posedge clk) begin
		dt1    <= dt1_m[cur];
		mul    <= mul_m[cur];
		tl     <= tl_m[cur];
		ks     <= ks_m[cur];
		ar     <= ar_m[cur];
		d1r    <= d1r_m[cur];
		d2r    <= d2r_m[cur];
		d1l    <= d1l_m[cur];
		rr     <= rr_m[cur];
		ssg_eg <= ssg_m[cur];
		fnum   <= fnum_m[cur_ch];
		block  <= block_m[cur_ch];
		fb     <= fb_m[cur_ch];
		alg    <= alg_m[cur_ch];
	end

	a_slot_in_range: assert property (@(posedge clk) disable iff (rst)
		slot_idx < SLOT_W'(NUM_SLOT));

endmodule

//--- fm_timers.sv
`timescale 1ns/100ps

module fm_timers #(
	parameter int NUM_CH = 6
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       ring_wrap,
	input  logic [9:0] value_a,
	input  logic [7:0] value_b,
	input  logic       load_a,
	input  logic       load_b,
	input  logic       en_flag_a,
	input  logic       en_flag_b,
	input  logic       clr_a,
	input  logic       clr_b,
	output logic       flag_a,
	output logic       flag_b,
	output logic       irq
);

	localparam int RING_LEN = NUM_CH * fm_reg_map_pkg::OPS_PER_CH;

	logic [9:0] cnt_a;
	logic [7:0] cnt_b;
	logic [3:0] pre_b;
	logic       tick_b;
	logic       ovf_a;
	logic       ovf_b;

	// timer b runs 16 times slower than a
	assign tick_b = ring_wrap && pre_b == 4'hF;
	assign ovf_a  = ring_wrap && load_a && cnt_a == 10'h3FF;
	assign ovf_b  = tick_b && load_b && cnt_b == 8'hFF;
	assign irq    = flag_a || flag_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_a  <= '0;
			cnt_b  <= '0;
			pre_b  <= '0;
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			if (ring_wrap) begin
				pre_b <= pre_b + 4'd1;
			end
			// stopped timer sits at its start value
			if (!load_a || ovf_a) begin
				cnt_a <= value_a;
			end else if (ring_wrap) begin
				cnt_a <= cnt_a + 10'd1;
			end
			if (!load_b || ovf_b) begin
				cnt_b <= value_b;
			end else if (tick_b) begin
				cnt_b <= cnt_b + 8'd1;
			end
			if (ovf_a && en_flag_a) begin
				flag_a <= 1'b1;
			end else if (clr_a) begin
				flag_a <= 1'b0;
			end
			if (ovf_b && en_flag_b) begin
				flag_b <= 1'b1;
			end else if (clr_b) begin
				flag_b <= 1'b0;
			end
		end
	end

	a_flag_a_en: assert property (@(posedge clk) disable iff (rst)
		$rose(flag_a) |-> $past(en_flag_a));
	a_flag_b_en: assert property (@(posedge clk) disable iff (rst)
		$rose(flag_b) |-> $past(en_flag_b));
	// a ring lasts at least one clock per slot
	a_wrap_spacing: assert property (@(posedge clk) disable iff (rst)
		ring_wrap |=> !ring_wrap [*(RING_LEN - 1)]);

endmodule

//--- tb_fm_regs.sv
`timescale 1ns/100ps

module tb_fm_regs;

	localparam int NUM_CH = 6;
	localparam int OPS = fm_reg_map_pkg::OPS_PER_CH;
	localparam int NUM_SLOT = NUM_CH * OPS;
	localparam int SLOT_W = $clog2(NUM_SLOT);
	// limits in clocks or bus cycles
	localparam int ACK_LIMIT = 400;
	localparam int POLL_LIMIT = 200;
	localparam int SLOT_LIMIT = 400;
	localparam int RING_LIMIT = 400;
	localparam int IRQ_LIMIT = 2000;

	logic              clk;
	logic              rst;
	logic              cyc;
	logic              stb;
	logic              we;
	logic [1:0]        adr;
	logic [7:0]        dat_w;
	logic [7:0]        dat_r;
	logic              ack;
	logic              irq;
	logic [SLOT_W-1:0] slot_idx;
	logic              keyon;
	logic [2:0]        dt1;
	logic [3:0]        mul;
	logic [6:0]        tl;
	logic [1:0]        ks;
	logic [4:0]        ar;
	logic [4:0]        d1r;
	logic [4:0]        d2r;
	logic [3:0]        d1l;
	logic [3:0]        rr;
	logic [3:0]        ssg_eg;
	logic [10:0]       fnum;
	logic [2:0]        block;
	logic [2:0]        fb;
	logic [2:0]        alg;
	logic              lfo_en;
	logic [2:0]        lfo_freq;
	logic [8:0]        pcm;
	logic              pcm_en;
	logic              eg_stop;
	logic              pg_stop;

	int          errors;
	int          tests;
	int          failed_tests;
	int          test_err0;
	// filled by wb_write for the back-pressure check
	int          busy_cycles;
	logic        ack_busy;

	fm_regs_top #(
		.NUM_CH (NUM_CH)
	) i_dut (
		.clk      (clk),
		.rst      (rst),
		.cyc      (cyc),
		.stb      (stb),
		.we       (we),
		.adr      (adr),
		.dat_w    (dat_w),
		.dat_r    (dat_r),
		.ack      (ack),
		.irq      (irq),
		.slot_idx (slot_idx),
		.keyon    (keyon),
		.dt1      (dt1),
		.mul      (mul),
		.tl       (tl),
		.ks       (ks),
		.ar       (ar),
		.d1r      (d1r),
		.d2r      (d2r),
		.d1l      (d1l),
		.rr       (rr),
		.ssg_eg   (ssg_eg),
		.fnum     (fnum),
		.block    (block),
		.fb       (fb),
		.alg      (alg),
		.lfo_en   (lfo_en),
		.lfo_freq (lfo_freq),
		.pcm      (pcm),
		.pcm_en   (pcm_en),
		.eg_stop  (eg_stop),
		.pg_stop  (pg_stop)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("[FAIL] t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
		errors++;
	endtask

	task automatic report_error(input string what);
		$display("[FAIL] t=%0t %s", $time, what);
		errors++;
	endtask

	task automatic start_test();
		test_err0 = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_err0) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", name, errors - test_err0);
		end
	endtask

	// called on a falling edge, returns on a falling edge with the bus idle
	task automatic wb_write(input logic [1:0] port, input logic [7:0] data);
		int n;
		n = 0;
		busy_cycles = 0;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b1;
		adr = port;
		dat_w = data;
		while (!ack && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
			if (!ack && dat_r[fm_host_pkg::ST_BUSY]) begin
				busy_cycles++;
			end
		end
		ack_busy = dat_r[fm_host_pkg::ST_BUSY];
		if (!ack) begin
			report_error("write was never acked");
		end
		// the write lands at the end of the ack cycle
		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(negedge clk);
	endtask

	task automatic wb_read(input logic [1:0] port, output logic [7:0] data);
		int n;
		n = 0;
		cyc = 1'b1;
		stb = 1'b1;
		we = 1'b0;
		adr = port;
		while (!ack && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		data = dat_r;
		if (!ack) begin
			report_error("read was never acked");
		end
		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		@(negedge clk);
	endtask

	task automatic reg_write(input bit bank, input logic [7:0] addr, input logic [7:0] data);
		wb_write(bank ? fm_host_pkg::PORT_ADDR1 : fm_host_pkg::PORT_ADDR0, addr);
		wb_write(bank ? fm_host_pkg::PORT_DATA1 : fm_host_pkg::PORT_DATA0, data);
	endtask

	task automatic wait_not_busy();
		logic [7:0] st;
		int n;
		n = 0;
		st = 8'h80;
		while (st[fm_host_pkg::ST_BUSY] && n < POLL_LIMIT) begin
			wb_read(fm_host_pkg::PORT_ADDR0, st);
			n++;
		end
		if (st[fm_host_pkg::ST_BUSY]) begin
			report_error("busy never cleared");
		end
	endtask

	task automatic wait_slot(input int target);
		int n;
		n = 0;
		while (int'(slot_idx) != target && n < SLOT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (int'(slot_idx) != target) begin
			report_error($sformatf("slot index never reached %0d", target));
		end
	endtask

	// clocks until the slot index next returns to 0
	task automatic wait_ring_start(output int n);
		logic [SLOT_W-1:0] prev;
		bit                found;
		n = 0;
		found = 1'b0;
		while (!found && n < RING_LIMIT) begin
			prev = slot_idx;
			@(negedge clk);
			n++;
			found = slot_idx == '0 && prev != '0;
		end
		if (!found) begin
			report_error("slot index never returned to 0");
		end
	endtask

	// first ring after a divisor change may still hold an old slot period
	task automatic ring_clocks(output int n);
		wait_ring_start(n);
		wait_ring_start(n);
		wait_ring_start(n);
	endtask

	task automatic test_global();
		logic [7:0] v_lfo;
		logic [7:0] v_pcm;
		logic [7:0] v_dac;
		logic [7:0] v_pen;
		logic [7:0] v_tst;
		start_test();
		v_lfo = 8'($urandom);
		v_pcm = 8'($urandom);
		v_dac = 8'($urandom);
		v_pen = 8'($urandom);
		v_tst = 8'($urandom);
		reg_write(1'b0, fm_reg_map_pkg::REG_LFO, v_lfo);
		reg_write(1'b0, fm_reg_map_pkg::REG_PCM, v_pcm);
		reg_write(1'b0, fm_reg_map_pkg::REG_DACTEST, v_dac);
		reg_write(1'b0, fm_reg_map_pkg::REG_PCM_EN, v_pen);
		reg_write(1'b0, fm_reg_map_pkg::REG_TESTYM, v_tst);
		if (lfo_en !== v_lfo[3]) report_mismatch("lfo_en", lfo_en, v_lfo[3]);
		if (lfo_freq !== v_lfo[2:0]) report_mismatch("lfo_freq", lfo_freq, v_lfo[2:0]);
		// pcm lsb sits in bit 3 of the dac test register
		if (pcm !== {v_pcm, v_dac[3]}) report_mismatch("pcm", pcm, {v_pcm, v_dac[3]});
		if (pcm_en !== v_pen[7]) report_mismatch("pcm_en", pcm_en, v_pen[7]);
		// eg stop in bit 5, pg stop in bit 3
		if (eg_stop !== v_tst[5]) report_mismatch("eg_stop", eg_stop, v_tst[5]);
		if (pg_stop !== v_tst[3]) report_mismatch("pg_stop", pg_stop, v_tst[3]);
		end_test("global registers");
	endtask

	task automatic test_slot_writes();
		int         lo;
		int         op;
		int         slot [2];
		logic [7:0] v_tl [2];
		logic [7:0] v_ksar [2];
		logic [7:0] v_dm [2];
		logic [7:0] v_d1r [2];
		logic [7:0] v_d2r [2];
		logic [7:0] v_lrr [2];
		logic [7:0] v_ssg [2];
		int         cf;
		logic [7:0] v_blk;
		logic [7:0] v_flo;
		logic [7:0] v_fba;
		start_test();
		for (int b = 0; b < 2; b++) begin
			lo = $urandom % 3;
			op = $urandom % 4;
			slot[b] = (b * 3 + lo) * OPS + op;
			v_tl[b] = 8'($urandom);
			v_ksar[b] = 8'($urandom);
			v_dm[b] = 8'($urandom);
			v_d1r[b] = 8'($urandom);
			v_d2r[b] = 8'($urandom);
			v_lrr[b] = 8'($urandom);
			v_ssg[b] = 8'($urandom);
			reg_write(b[0], {fm_reg_map_pkg::GRP_TL, 2'(op), 2'(lo)}, v_tl[b]);
			reg_write(b[0], {fm_reg_map_pkg::GRP_KS_AR, 2'(op), 2'(lo)}, v_ksar[b]);
			reg_write(b[0], {fm_reg_map_pkg::GRP_DT1_MUL, 2'(op), 2'(lo)}, v_dm[b]);
			reg_write(b[0], {fm_reg_map_pkg::GRP_AM_D1R, 2'(op), 2'(lo)}, v_d1r[b]);
			reg_write(b[0], {fm_reg_map_pkg::GRP_D2R, 2'(op), 2'(lo)}, v_d2r[b]);
			reg_write(b[0], {fm_reg_map_pkg::GRP_D1L_RR, 2'(op), 2'(lo)}, v_lrr[b]);
			reg_write(b[0], {fm_reg_map_pkg::GRP_SSG, 2'(op), 2'(lo)}, v_ssg[b]);
		end
		// block and fnum msbs first, the low byte commits both
		cf = $urandom % NUM_CH;
		v_blk = 8'($urandom) & 8'h3F;
		v_flo = 8'($urandom);
		v_fba = 8'($urandom);
		reg_write(cf >= 3, fm_reg_map_pkg::GRP_BLOCK | 8'(cf % 3), v_blk);
		reg_write(cf >= 3, fm_reg_map_pkg::GRP_FNUM_LO | 8'(cf % 3), v_flo);
		reg_write(cf >= 3, fm_reg_map_pkg::GRP_FB_ALG | 8'(cf % 3), v_fba);
		wait_not_busy();
		for (int b = 0; b < 2; b++) begin
			wait_slot(slot[b]);
			if (tl !== v_tl[b][6:0]) report_mismatch("tl", tl, v_tl[b][6:0]);
			if (ks !== v_ksar[b][7:6]) report_mismatch("ks", ks, v_ksar[b][7:6]);
			if (ar !== v_ksar[b][4:0]) report_mismatch("ar", ar, v_ksar[b][4:0]);
			if (dt1 !== v_dm[b][6:4]) report_mismatch("dt1", dt1, v_dm[b][6:4]);
			if (mul !== v_dm[b][3:0]) report_mismatch("mul", mul, v_dm[b][3:0]);
			if (d1r !== v_d1r[b][4:0]) report_mismatch("d1r", d1r, v_d1r[b][4:0]);
			if (d2r !== v_d2r[b][4:0]) report_mismatch("d2r", d2r, v_d2r[b][4:0]);
			if (d1l !== v_lrr[b][7:4]) report_mismatch("d1l", d1l, v_lrr[b][7:4]);
			if (rr !== v_lrr[b][3:0]) report_mismatch("rr", rr, v_lrr[b][3:0]);
			if (ssg_eg !== v_ssg[b][3:0]) report_mismatch("ssg_eg", ssg_eg, v_ssg[b][3:0]);
		end
		wait_slot(cf * OPS);
		if (fnum !== {v_blk[2:0], v_flo}) report_mismatch("fnum", fnum, {v_blk[2:0], v_flo});
		if (block !== v_blk[5:3]) report_mismatch("block", block, v_blk[5:3]);
		if (fb !== v_fba[5:3]) report_mismatch("fb", fb, v_fba[5:3]);
		if (alg !== v_fba[2:0]) report_mismatch("alg", alg, v_fba[2:0]);
		end_test("slot writes");
	endtask

	task automatic test_ring_period();
		int n;
		start_test();
		ring_clocks(n);
		if (n != NUM_SLOT * fm_reg_map_pkg::DIV_RESET) begin
			report_mismatch("ring clocks", n, NUM_SLOT * fm_reg_map_pkg::DIV_RESET);
		end
		reg_write(1'b0, fm_reg_map_pkg::REG_CLK_N3, 8'h00);
		ring_clocks(n);
		if (n != NUM_SLOT * 3) report_mismatch("ring clocks", n, NUM_SLOT * 3);
		reg_write(1'b0, fm_reg_map_pkg::REG_CLK_N2, 8'h00);
		ring_clocks(n);
		if (n != NUM_SLOT * 2) report_mismatch("ring clocks", n, NUM_SLOT * 2);
		// back to the slow ring for the later tests
		reg_write(1'b0, fm_reg_map_pkg::REG_CLK_N6, 8'h00);
		end_test("ring period");
	endtask

	task automatic test_keyon();
		logic [3:0] mask;
		int         kb;
		int         klo;
		start_test();
		mask = 4'($urandom % 15 + 1);
		kb = $urandom % 2;
		klo = $urandom % 3;
		reg_write(1'b0, fm_reg_map_pkg::REG_KON, {mask, 1'b0, kb[0], 2'(klo)});
		wait_not_busy();
		for (int i = 0; i < OPS; i++) begin
			wait_slot((kb * 3 + klo) * OPS + i);
			if (keyon !== mask[i]) report_mismatch("keyon", keyon, mask[i]);
		end
		end_test("key-on");
	endtask

	task automatic test_timer_a();
		logic [7:0] st;
		int         n;
		start_test();
		// 3FDh, three ring wraps to overflow
		reg_write(1'b0, fm_reg_map_pkg::REG_CLKA1, 8'hFF);
		reg_write(1'b0, fm_reg_map_pkg::REG_CLKA2, 8'h01);
		reg_write(1'b0, fm_reg_map_pkg::REG_TIMER, 8'h05);
		n = 0;
		while (!irq && n < IRQ_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!irq) begin
			report_error("irq never rose for timer A");
		end
		wb_read(fm_host_pkg::PORT_ADDR0, st);
		if (st[fm_host_pkg::ST_FLAG_A] !== 1'b1) begin
			report_mismatch("flag_a", st[fm_host_pkg::ST_FLAG_A], 1'b1);
		end
		if (st[fm_host_pkg::ST_FLAG_B] !== 1'b0) begin
			report_mismatch("flag_b", st[fm_host_pkg::ST_FLAG_B], 1'b0);
		end
		// clear flag a and stop the timer
		reg_write(1'b0, fm_reg_map_pkg::REG_TIMER, 8'h10);
		if (irq !== 1'b0) report_mismatch("irq", irq, 1'b0);
		end_test("timer A");
	endtask

	task automatic test_back_pressure();
		int         lo1;
		int         op1;
		int         s1;
		int         lo2;
		int         op2;
		int         s2;
		logic [7:0] v1;
		logic [7:0] v2;
		start_test();
		lo1 = $urandom % 3;
		op1 = $urandom % 4;
		s1 = (3 + lo1) * OPS + op1;
		lo2 = $urandom % 3;
		op2 = $urandom % 4;
		s2 = lo2 * OPS + op2;
		v1 = 8'($urandom);
		v2 = 8'($urandom);
		wb_write(fm_host_pkg::PORT_ADDR1, {fm_reg_map_pkg::GRP_TL, 2'(op1), 2'(lo1)});
		// target just went by, so the update waits most of a ring
		wait_slot((s1 + 1) % NUM_SLOT);
		wb_write(fm_host_pkg::PORT_DATA1, v1);
		wb_write(fm_host_pkg::PORT_ADDR0, {fm_reg_map_pkg::GRP_TL, 2'(op2), 2'(lo2)});
		wb_write(fm_host_pkg::PORT_DATA0, v2);
		if (busy_cycles == 0) begin
			report_error("second data write was acked without waiting on busy");
		end
		if (ack_busy !== 1'b0) report_mismatch("busy at ack", ack_busy, 1'b0);
		wait_not_busy();
		wait_slot(s1);
		if (tl !== v1[6:0]) report_mismatch("tl", tl, v1[6:0]);
		wait_slot(s2);
		if (tl !== v2[6:0]) report_mismatch("tl", tl, v2[6:0]);
		end_test("back-pressure");
	endtask

	initial begin
		void'($urandom(32'hd9f1));
		errors = 0;
		tests = 0;
		failed_tests = 0;
		test_err0 = 0;
		busy_cycles = 0;
		ack_busy = 1'b0;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		test_global();
		test_slot_writes();
		test_ring_period();
		test_keyon();
		test_timer_a();
		test_back_pressure();
		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests, failed_tests, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule
